//--- verilog/isaPkg.sv
// instruction set definitions
`default_nettype none

package isaPkg;

   // datapath word, all registers and PCs
   typedef logic [15:0] word_t;

   // register number, eight entries
   typedef logic [2:0] regAddr_t;

   // major opcode, instr[15:11]
   typedef logic [4:0] opcode_t;

   // top three opcode bits shared by branches
   typedef logic [2:0] opGroup_t;

   // jump and link, pc-relative target
   localparam opcode_t opJal = 5'b00110;

   // jump and link through Rs
   localparam opcode_t opJalr = 5'b00111;

   // beqz/bnez/bltz/bgez all start with 011
   // low two opcode bits pick the condition
   localparam opGroup_t branchGroup = 3'b011;

   // return address always lands here
   localparam regAddr_t linkReg = 3'd7;

   // register file depth
   localparam int numRegs = 8;

endpackage

`default_nettype wire

//--- verilog/decodePkg.sv
// decode stage bundles
`default_nettype none

package decodePkg;
   import isaPkg::*;

   // level controls from the control unit
   typedef struct packed {
      logic lbi;     // write imm instead of wb data
      logic link;    // write return address
      logic bFlag;   // treat as branch regardless of opcode
      logic regJmp;  // target is rs + imm
      logic halt;    // no branching while halted
   } decodeCtrl_t;

   // one register write request, 20 bits
   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } wbPort_t;

   // both read ports together
   typedef struct packed {
      word_t rd1;
      word_t rd2;
   } regRead_t;

endpackage

`default_nettype wire

//--- verilog/regFile.sv
// eight entry register file
`timescale 1ns/1ps
`default_nettype none

module regFile
   import isaPkg::*, decodePkg::*;
(
   input  wire      clk,
   input  wire      rstN,
   input  regAddr_t rdAddr1,
   input  regAddr_t rdAddr2,
   input  wbPort_t  wr,
   output regRead_t rd
);

   // register storage
   word_t regs [numRegs];

   // single write port, sync clear
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // async reads
   // no write bypass, same cycle read sees old value
   always_comb begin
      rd.rd1 = regs[rdAddr1];
      rd.rd2 = regs[rdAddr2];
   end

endmodule

`default_nettype wire

//--- verilog/branchResolve.sv
// branch condition and next pc
`timescale 1ns/1ps
`default_nettype none

module branchResolve
   import isaPkg::*, decodePkg::*;
(
   input  wire         clk,
   input  wire         rstN,
   input  opcode_t     opcode,
   input  wire  [1:0]  cond,
   input  decodeCtrl_t ctrl,
   input  word_t       rs,
   input  word_t       imm,
   input  word_t       pcPlus2,
   output word_t       nextPc,
   output logic        pcSel,
   output logic        branchTaken
);

   logic isBranch;
   logic condMet;
   logic rsZero;
   logic rsNeg;

   // flags on the first read value
   assign rsZero = (rs == '0);
   assign rsNeg  = rs[15];

   // opcode group or forced by control
   assign isBranch = (opcode[4:2] == branchGroup) | ctrl.bFlag;

   // beqz, bnez, bltz, bgez
   always_comb begin
      case (cond)
         2'b00:   condMet = rsZero;
         2'b01:   condMet = ~rsZero;
         2'b10:   condMet = rsNeg;
         default: condMet = ~rsNeg;
      endcase
   end

   assign pcSel = isBranch & condMet & ~ctrl.halt;

   // taken branch wins over register jump
   always_comb begin
      if (pcSel) begin
         nextPc = pcPlus2 + imm;
      end else if (ctrl.regJmp) begin
         nextPc = rs + imm;
      end else begin
         nextPc = pcPlus2;
      end
   end

   // taken flag, one cycle late
   always_ff @(posedge clk) begin
      if (!rstN) begin
         branchTaken <= 1'b0;
      end else begin
         branchTaken <= pcSel;
      end
   end

endmodule

`default_nettype wire

//--- verilog/linkTracker.sv
// jump and link write control
`timescale 1ns/1ps
`default_nettype none

module linkTracker
   import isaPkg::*, decodePkg::*;
#(
   parameter int linkShadow = 3
) (
   input  wire      clk,
   input  wire      rstN,
   input  opcode_t  opcode,
   input  regAddr_t rsAddr,
   input  wire      lbi,
   input  wire      link,
   input  word_t    imm,
   input  word_t    pcPlus2,
   input  wbPort_t  wbIn,
   output wbPort_t  wrOut,
   output regAddr_t read1Sel,
   output word_t    jmpData
);

   // link flags for execute, memory, writeback
   logic [linkShadow-1:0] shadow;
   logic linkNow;
   logic shadowBusy;
   word_t wrData;

   // jal or jalr sitting in decode
   assign linkNow = (opcode == opJal) | (opcode == opJalr);

   // shadow[0] is the execute slot
   assign shadowBusy = |shadow;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         shadow <= '0;
      end else begin
         shadow[0] <= linkNow;
         for (int i = 1; i < linkShadow; i++) begin
            shadow[i] <= shadow[i-1];
         end
      end
   end

   // return address first, then imm for lbi, then wb data
   // a link in execute keeps the port disabled, so its data never lands
   always_comb begin
      if (link | linkNow) begin
         wrData = pcPlus2;
      end else if (lbi) begin
         wrData = imm;
      end else begin
         wrData = wbIn.data;
      end
   end

   // link writes r7 now
   // any wb behind a link's empty slots is dropped
   assign wrOut.data = wrData;
   assign wrOut.addr = linkNow ? linkReg : wbIn.addr;
   assign wrOut.en   = linkNow | (wbIn.en & ~shadowBusy);

   // jal reads r7 while its own write is in flight
   // a jal opcode is itself the link in decode
   assign read1Sel = (opcode == opJal) ? linkReg : rsAddr;

   // hold last link write data
   always_ff @(posedge clk) begin
      if (!rstN) begin
         jmpData <= '0;
      end else if (linkNow) begin
         jmpData <= wrData;
      end
   end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
// pipeline decode stage
`timescale 1ns/1ps
`default_nettype none

module decodeStage
   import isaPkg::*, decodePkg::*;
#(
   parameter int linkShadow = 3
) (
   input  wire         clk,
   input  wire         rstN,
   input  word_t       instr,
   input  word_t       imm,
   input  word_t       pcNow,
   input  decodeCtrl_t ctrl,
   input  wbPort_t     wbIn,
   output regRead_t    regs,
   output word_t       jmpData,
   output word_t       nextPc,
   output logic        pcSel,
   output logic        branchTaken
);

   // instruction fields
   opcode_t    opcode;
   regAddr_t   rsAddr;
   regAddr_t   rtAddr;
   logic [1:0] cond;

   word_t    pcPlus2;
   wbPort_t  wrPort;
   regAddr_t read1Sel;

   assign opcode = instr[15:11];
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];
   // branch condition, low opcode bits
   assign cond   = instr[12:11];

   // return address and fall-through pc
   assign pcPlus2 = pcNow + 16'd2;

   // r7 write and wb shadow
   linkTracker #(
      .linkShadow(linkShadow)
   ) u_link (
      .clk      (clk),
      .rstN     (rstN),
      .opcode   (opcode),
      .rsAddr   (rsAddr),
      .lbi      (ctrl.lbi),
      .link     (ctrl.link),
      .imm      (imm),
      .pcPlus2  (pcPlus2),
      .wbIn     (wbIn),
      .wrOut    (wrPort),
      .read1Sel (read1Sel),
      .jmpData  (jmpData)
   );

   regFile u_regs (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddr1 (read1Sel),
      .rdAddr2 (rtAddr),
      .wr      (wrPort),
      .rd      (regs)
   );

   // branches test the first read port
   branchResolve u_branch (
      .clk         (clk),
      .rstN        (rstN),
      .opcode      (opcode),
      .cond        (cond),
      .ctrl        (ctrl),
      .rs          (regs.rd1),
      .imm         (imm),
      .pcPlus2     (pcPlus2),
      .nextPc      (nextPc),
      .pcSel       (pcSel),
      .branchTaken (branchTaken)
   );

endmodule

`default_nettype wire

//--- bench/tbClock.sv
// clock and reset source
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic clk,
   output logic rstN
);

   // rising edges seen so far, stops at 8
   int edges = 0;

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      if (edges < 8) begin
         edges <= edges + 1;
      end
   end

   // low across the first eight rising edges
   assign rstN = (edges >= 8);

endmodule

`default_nettype wire

//--- bench/decodeChecker.sv
// decode output checker
`timescale 1ns/1ps
`default_nettype none

module decodeChecker
   import isaPkg::*, decodePkg::*;
(
   input  wire      clk,
   input  wire      valid,
   input  regRead_t regs,
   input  word_t    jmpData,
   input  word_t    nextPc,
   input  wire      pcSel,
   input  wire      branchTaken,
   input  regRead_t expRegs,
   input  wire      expPcSel,
   input  word_t    expNextPc,
   input  word_t    expJmpData,
   output int       errCount,
   output int       checkCount
);

   int errors = 0;
   int checks = 0;
   // expected pcSel of the vector before
   // idle cycles ahead of the first vector give zero
   logic lastPcSel = 1'b0;

   assign errCount   = errors;
   assign checkCount = checks;

   task automatic compareWord(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         errors++;
         $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // outputs settle in the first half cycle
   always @(negedge clk) begin
      if (valid) begin
         checks++;
         compareWord("rd1", expRegs.rd1, regs.rd1);
         compareWord("rd2", expRegs.rd2, regs.rd2);
         compareWord("pcSel", {15'd0, expPcSel}, {15'd0, pcSel});
         compareWord("nextPc", expNextPc, nextPc);
         compareWord("jmpData", expJmpData, jmpData);
         // last cycle's branch decision, registered
         compareWord("branchTaken", {15'd0, lastPcSel}, {15'd0, branchTaken});
         lastPcSel = expPcSel;
      end
   end

endmodule

`default_nettype wire

//--- bench/decodeTb.sv
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decodeTb
   import isaPkg::*, decodePkg::*;
();

   localparam int resetTimeout = 50;
   localparam int runTimeout   = 1000;

   // one input line, stimulus then expected values
   typedef struct packed {
      word_t       instr;
      word_t       imm;
      word_t       pcNow;
      decodeCtrl_t ctrl;
      wbPort_t     wb;
      regRead_t    expRegs;
      logic        expPcSel;
      word_t       expNextPc;
      word_t       expJmpData;
   } vector_t;

   logic     clk;
   logic     rstN;
   regRead_t regs;
   word_t    jmpData;
   word_t    nextPc;
   logic     pcSel;
   logic     branchTaken;
   int       errCount;
   int       checkCount;

   // vector on the DUT inputs, all zero until the first edge out of reset
   vector_t cur = '0;
   logic    valid = 1'b0;
   logic    loaded = 1'b0;
   logic    allSent = 1'b0;
   vector_t vectors[$];
   int      nextIdx = 0;
   int      badLines = 0;

   tbClock u_clock (
      .clk  (clk),
      .rstN (rstN)
   );

   decodeStage #(
      .linkShadow(3)
   ) u_dut (
      .clk         (clk),
      .rstN        (rstN),
      .instr       (cur.instr),
      .imm         (cur.imm),
      .pcNow       (cur.pcNow),
      .ctrl        (cur.ctrl),
      .wbIn        (cur.wb),
      .regs        (regs),
      .jmpData     (jmpData),
      .nextPc      (nextPc),
      .pcSel       (pcSel),
      .branchTaken (branchTaken)
   );

   decodeChecker u_check (
      .clk         (clk),
      .valid       (valid),
      .regs        (regs),
      .jmpData     (jmpData),
      .nextPc      (nextPc),
      .pcSel       (pcSel),
      .branchTaken (branchTaken),
      .expRegs     (cur.expRegs),
      .expPcSel    (cur.expPcSel),
      .expNextPc   (cur.expNextPc),
      .expJmpData  (cur.expJmpData),
      .errCount    (errCount),
      .checkCount  (checkCount)
   );

   // one vector per rising edge once out of reset
   always @(posedge clk) begin
      if (rstN && loaded) begin
         if (nextIdx < vectors.size()) begin
            cur     <= vectors[nextIdx];
            valid   <= 1'b1;
            nextIdx <= nextIdx + 1;
         end else begin
            valid   <= 1'b0;
            allSent <= 1'b1;
         end
      end
   end

   initial begin
      int         fd;
      int         n;
      int         waits;
      string      line;
      word_t      fInstr, fImm, fPc, fData, fRd1, fRd2, fNext, fJmp;
      logic [4:0] fCtrl;
      logic       fEn;
      logic       fSel;
      regAddr_t   fAddr;

      fd = $fopen("bench/decodeInput.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/decodeInput.txt, there is no stimulus to run");
         $display("Finished with errors");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // comment and blank lines hold no vector
            if (n > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                           fInstr, fImm, fPc, fCtrl, fEn, fAddr, fData,
                           fRd1, fRd2, fSel, fNext, fJmp);
               if (n == 12) begin
                  vectors.push_back(vector_t'({fInstr, fImm, fPc, fCtrl, fEn, fAddr,
                                               fData, fRd1, fRd2, fSel, fNext, fJmp}));
               end else begin
                  $display("input line with %0d fields skipped: %s", n, line);
                  badLines++;
               end
            end
         end
         $fclose(fd);
         loaded = 1'b1;

         // reset release
         waits = 0;
         while (!rstN && waits < resetTimeout) begin
            @(negedge clk);
            waits++;
         end
         // every vector applied and checked
         waits = 0;
         while (!allSent && waits < runTimeout) begin
            @(negedge clk);
            waits++;
         end

         if (!allSent) begin
            $display("timed out waiting for reset release or for the last vector");
            $display("Finished with errors");
         end else begin
            $display("checked %0d of %0d vectors, %0d errors, %0d bad input lines",
                     checkCount, vectors.size(), errCount, badLines);
            if (errCount == 0 && badLines == 0 && checkCount > 0
                && checkCount == vectors.size()) begin
               $display("Finished with no errors");
            end else begin
               $display("Finished with errors");
            end
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- files.f
verilog/isaPkg.sv
verilog/decodePkg.sv
verilog/regFile.sv
verilog/branchResolve.sv
verilog/linkTracker.sv
verilog/decodeStage.sv
bench/tbClock.sv
bench/decodeChecker.sv
bench/decodeTb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f files.f --top-module decodeTb -o decodeSim
./obj_dir/decodeSim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "simulation reported errors"
   exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi

//--- bench/decodeInput.txt
# instr imm pcNow ctrl(lbi link bFlag regJmp halt) wbEn wbAddr wbData
# then expected rd1 rd2 pcSel nextPc jmpData, all hex
0000 0000 0100 00 1 1 1111 0000 0000 0 0102 0000
0140 0000 0102 00 1 2 2222 1111 0000 0 0104 0000
0260 0000 0104 00 1 3 8000 2222 0000 0 0106 0000
0380 4444 0106 10 1 4 dead 8000 0000 0 0108 0000
04a0 0555 0108 10 1 5 beef 4444 0000 0 010a 0000
05c0 0000 010a 00 1 6 6666 0555 0000 0 010c 0000
0620 0000 010c 00 0 2 ffff 6666 1111 0 010e 0000
6000 0010 0200 00 0 0 0000 0000 0000 1 0212 0000
6100 0010 0202 00 0 0 0000 1111 0000 0 0204 0000
6900 0010 0204 00 0 0 0000 1111 0000 1 0216 0000
6800 0010 0206 00 0 0 0000 0000 0000 0 0208 0000
7300 0010 0208 00 0 0 0000 8000 0000 1 021a 0000
7100 0010 020a 00 0 0 0000 1111 0000 0 020c 0000
7900 0010 020c 00 0 0 0000 1111 0000 1 021e 0000
7800 0010 020e 01 0 0 0000 0000 0000 0 0210 0000
0000 0010 0210 04 0 0 0000 0000 0000 1 0222 0000
0500 0100 0300 02 0 0 0000 0555 0000 0 0655 0000
3260 0020 0400 00 1 6 aaaa 0000 8000 0 0402 0000
07c0 0000 0402 00 1 1 0bad 0402 6666 0 0404 0402
0140 0000 0404 00 1 2 0bad 1111 2222 0 0406 0402
0180 0000 0406 00 1 4 0bad 1111 4444 0 0408 0402
0280 0000 0408 00 1 4 0c0c 2222 4444 0 040a 0402
3c80 0000 0500 00 0 0 0000 0c0c 0c0c 0 0502 0402
0780 0000 0502 00 0 0 0000 0502 0c0c 0 0504 0502
